// ==== verilog/panelPkg.sv ====
`default_nettype none

package panelPkg;

   ////////////////////////////////////////////////////////////
   // Event payload
   ////////////////////////////////////////////////////////////

   localparam int PANEL_W = 16;

   // One event word, read either as a switch snapshot or as a
   // set of newly pressed buttons
   typedef union packed
   {
      logic [PANEL_W-1:0] swView;
      struct packed
      {
         logic [10:0] reserved;
         logic        left;
         logic        right;
         logic        up;
         logic        down;
         logic        centre;
      } btnView;
   } panelWord;

   ////////////////////////////////////////////////////////////
   // Timing and sizes
   ////////////////////////////////////////////////////////////

   // Cycles per panel sample tick, scaled down for simulation
   localparam int SAMPLE_DIV = 16;

   // Cycles each display digit stays lit
   localparam int SCAN_DIV = 8;

   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_LEVEL_W = 4;

   // Display source select, taken from switches 7:4
   localparam logic [3:0] SEL_SWITCHES = 4'd0;
   localparam logic [3:0] SEL_BUTTONS = 4'd1;
   localparam logic [3:0] SEL_EVENTS = 4'd2;
   localparam logic [3:0] SEL_CYCLES = 4'd3;
   localparam logic [3:0] SEL_LEVEL = 4'd4;

endpackage

`default_nettype wire

// ==== verilog/panelSampler.sv ====
`timescale 1ns/10ps
`default_nettype none

module panelSampler
(
   input  wire                         selected_clk,
   input  wire                         res,
   input  wire [panelPkg::PANEL_W-1:0] sw,
   input  wire                         btnC,
   input  wire                         btnU,
   input  wire                         btnD,
   input  wire                         btnL,
   input  wire                         btnR,
   output logic                        evValid,
   output logic                        evIsButton,
   output panelPkg::panelWord          evWord,
   input  wire                         evReady
);

   import panelPkg::*;

   // Synchroniser stages, buttons packed as {left, right, up, down, centre}
   logic [PANEL_W-1:0] swMeta;
   logic [PANEL_W-1:0] swSync;
   logic [4:0] btnMeta;
   logic [4:0] btnSync;

   logic [$clog2(SAMPLE_DIV)-1:0] divCount;
   logic tick;
   logic service;
   logic accept;

   // Button state seen at the last serviced tick
   logic [4:0] btnPrev;
   logic [4:0] newPress;

   // Last switch word the FIFO has taken
   logic [PANEL_W-1:0] swSnap;

   assign tick = (divCount == $bits(divCount)'(SAMPLE_DIV - 1));

   // Ticks are ignored while an event waits for the FIFO
   assign service = tick & ~evValid;
   assign accept = evValid & evReady;
   assign newPress = btnSync & ~btnPrev;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         swMeta <= '0;
         swSync <= '0;
         btnMeta <= '0;
         btnSync <= '0;
         divCount <= '0;
         btnPrev <= '0;
         swSnap <= '0;
         evValid <= 1'b0;
      end
      else
      begin
         swMeta <= sw;
         swSync <= swMeta;
         btnMeta <= {btnL, btnR, btnU, btnD, btnC};
         btnSync <= btnMeta;
         divCount <= tick ? '0 : divCount + 1'b1;
         if (service)
         begin
            btnPrev <= btnSync;
            if ((|newPress) || (swSync != swSnap))
               evValid <= 1'b1;
         end
         else if (accept)
         begin
            evValid <= 1'b0;
            if (!evIsButton)
               swSnap <= evWord.swView;
         end
      end
   end

   // Payload only changes while no event is pending
   always_ff @(posedge selected_clk)
   begin
      if (service)
      begin
         if (|newPress)
         begin
            // New presses win over a switch change
            evIsButton <= 1'b1;
            evWord.btnView.reserved <= '0;
            evWord.btnView.left <= newPress[4];
            evWord.btnView.right <= newPress[3];
            evWord.btnView.up <= newPress[2];
            evWord.btnView.down <= newPress[1];
            evWord.btnView.centre <= newPress[0];
         end
         else
         begin
            evIsButton <= 1'b0;
            evWord.swView <= swSync;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/eventFifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module eventFifo
(
   input  wire                              selected_clk,
   input  wire                              res,
   input  wire                              evValid,
   input  wire                              evIsButton,
   input  wire panelPkg::panelWord          evWord,
   output logic                             evReady,
   output logic                             qValid,
   output logic                             qIsButton,
   output panelPkg::panelWord               qWord,
   input  wire                              qReady,
   output logic [panelPkg::FIFO_LEVEL_W-1:0] level
);

   import panelPkg::*;

   // Entry layout is {kind, payload}
   logic [PANEL_W:0] mem [FIFO_DEPTH];

   logic [$clog2(FIFO_DEPTH)-1:0] wrPtr;
   logic [$clog2(FIFO_DEPTH)-1:0] rdPtr;
   logic [FIFO_LEVEL_W-1:0] count;
   logic full;
   logic doWrite;
   logic doRead;

   assign full = (count == FIFO_LEVEL_W'(FIFO_DEPTH));
   assign evReady = ~full;
   assign qValid = (count != '0);

   assign doWrite = evValid & evReady;
   assign doRead = qValid & qReady;

   assign qIsButton = mem[rdPtr][PANEL_W];
   assign qWord = mem[rdPtr][PANEL_W-1:0];
   assign level = count;

   always_ff @(posedge selected_clk)
   begin
      if (doWrite)
         mem[wrPtr] <= {evIsButton, evWord};
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doWrite)
            wrPtr <= wrPtr + 1'b1;
         if (doRead)
            rdPtr <= rdPtr + 1'b1;
         // Occupancy only moves when one side is idle
         if (doWrite && !doRead)
            count <= count + 1'b1;
         else if (doRead && !doWrite)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/panelPorts.sv ====
`timescale 1ns/10ps
`default_nettype none

module panelPorts
(
   input  wire                              selected_clk,
   input  wire                              res,
   input  wire                              hold,
   input  wire                              qValid,
   input  wire                              qIsButton,
   input  wire panelPkg::panelWord          qWord,
   input  wire [panelPkg::FIFO_LEVEL_W-1:0] level,
   output logic                             qReady,
   output logic [31:0]                      displayWord,
   output logic [panelPkg::PANEL_W-1:0]     leds
);

   import panelPkg::*;

   logic [PANEL_W-1:0] portJ;
   logic [PANEL_W-1:0] portI;
   logic [31:0] eventCount;
   logic [31:0] cycleCount;
   logic [3:0] displaySel;
   logic [31:0] selWord;
   logic accept;

   // The hold switch stalls the queue
   assign qReady = ~hold;
   assign accept = qValid & qReady;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         portJ <= '0;
         portI <= '0;
         eventCount <= '0;
         cycleCount <= '0;
      end
      else
      begin
         cycleCount <= cycleCount + 1'b1;
         if (accept)
         begin
            eventCount <= eventCount + 1'b1;
            if (qIsButton)
               portI <= {{(PANEL_W - 5){1'b0}}, qWord.btnView.left, qWord.btnView.right,
                         qWord.btnView.up, qWord.btnView.down, qWord.btnView.centre};
            else
               portJ <= qWord.swView;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Display source
   ////////////////////////////////////////////////////////////

   assign displaySel = portJ[7:4];

   always_comb
   begin
      case (displaySel)
         SEL_SWITCHES: selWord = {{(32 - PANEL_W){1'b0}}, portJ};
         SEL_BUTTONS:  selWord = {{(32 - PANEL_W){1'b0}}, portI};
         SEL_EVENTS:   selWord = eventCount;
         SEL_CYCLES:   selWord = cycleCount;
         SEL_LEVEL:    selWord = {{(32 - FIFO_LEVEL_W){1'b0}}, level};
         default:      selWord = '0;
      endcase
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         displayWord <= '0;
      else
         displayWord <= selWord;
   end

   assign leds = displayWord[PANEL_W-1:0];

endmodule

`default_nettype wire

// ==== verilog/seg7Scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg7Scanner
(
   input  wire        selected_clk,
   input  wire        res,
   input  wire [31:0] displayWord,
   output logic [7:0] seg,
   output logic [7:0] an
);

   import panelPkg::*;

   logic [$clog2(SCAN_DIV)-1:0] divCount;
   logic step;
   logic [2:0] digit;
   logic active;
   logic [31:0] shownWord;
   logic [3:0] nibble;

   // Segments gfedcba, active low
   logic [6:0] segCode;

   assign step = (divCount == $bits(divCount)'(SCAN_DIV - 1));

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         divCount <= '0;
         digit <= 3'd7;
         active <= 1'b0;
      end
      else
      begin
         divCount <= step ? '0 : divCount + 1'b1;
         if (step)
         begin
            // First step after reset starts the scan on digit 0
            digit <= digit + 1'b1;
            active <= 1'b1;
         end
      end
   end

   // Word is captured as digit 0 comes up
   always_ff @(posedge selected_clk)
   begin
      if (step && (digit == 3'd7))
         shownWord <= displayWord;
   end

   assign nibble = shownWord[digit*4 +: 4];

   always_comb
   begin
      case (nibble)
         4'h0: segCode = 7'h40;
         4'h1: segCode = 7'h79;
         4'h2: segCode = 7'h24;
         4'h3: segCode = 7'h30;
         4'h4: segCode = 7'h19;
         4'h5: segCode = 7'h12;
         4'h6: segCode = 7'h02;
         4'h7: segCode = 7'h78;
         4'h8: segCode = 7'h00;
         4'h9: segCode = 7'h10;
         4'ha: segCode = 7'h08;
         4'hb: segCode = 7'h03;
         4'hc: segCode = 7'h46;
         4'hd: segCode = 7'h21;
         4'he: segCode = 7'h06;
         default: segCode = 7'h0e;
      endcase
   end

   // Decimal point in bit 7 stays dark
   assign seg = active ? {1'b1, segCode} : 8'hff;
   assign an = active ? ~(8'd1 << digit) : 8'hff;

endmodule

`default_nettype wire

// ==== verilog/panelTest.sv ====
`timescale 1ns/10ps
`default_nettype none

module panelTest
(
   input  wire                          selected_clk,
   input  wire                          res,
   input  wire [panelPkg::PANEL_W-1:0]  sw,
   input  wire                          btnC,
   input  wire                          btnU,
   input  wire                          btnD,
   input  wire                          btnL,
   input  wire                          btnR,
   input  wire                          hold,
   output wire [7:0]                    seg,
   output wire [7:0]                    an,
   output wire [panelPkg::PANEL_W-1:0]  leds
);

   import panelPkg::*;

   // Sampler to FIFO
   wire evValid;
   wire evIsButton;
   wire panelWord evWord;
   wire evReady;

   // FIFO to ports
   wire qValid;
   wire qIsButton;
   wire panelWord qWord;
   wire qReady;
   wire [FIFO_LEVEL_W-1:0] level;

   wire [31:0] displayWord;

   panelSampler sampler0
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sw           (sw),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .evValid      (evValid),
      .evIsButton   (evIsButton),
      .evWord       (evWord),
      .evReady      (evReady)
   );

   eventFifo fifo0
   (
      .selected_clk (selected_clk),
      .res          (res),
      .evValid      (evValid),
      .evIsButton   (evIsButton),
      .evWord       (evWord),
      .evReady      (evReady),
      .qValid       (qValid),
      .qIsButton    (qIsButton),
      .qWord        (qWord),
      .qReady       (qReady),
      .level        (level)
   );

   panelPorts ports0
   (
      .selected_clk (selected_clk),
      .res          (res),
      .hold         (hold),
      .qValid       (qValid),
      .qIsButton    (qIsButton),
      .qWord        (qWord),
      .level        (level),
      .qReady       (qReady),
      .displayWord  (displayWord),
      .leds         (leds)
   );

   seg7Scanner scanner0
   (
      .selected_clk (selected_clk),
      .res          (res),
      .displayWord  (displayWord),
      .seg          (seg),
      .an           (an)
   );

endmodule

`default_nettype wire

// ==== tb/panelTestTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module panelTestTb;

   import panelPkg::*;

   // Run limit from the number of display checks and per-check latency
   localparam int TEST_STEPS = 50;
   localparam int STEP_MARGIN = 320;
   localparam int TIMEOUT_CYCLES = TEST_STEPS * (SAMPLE_DIV + 8 * SCAN_DIV + STEP_MARGIN);

   logic selected_clk;
   logic res;
   logic [PANEL_W-1:0] sw;
   logic btnC;
   logic btnU;
   logic btnD;
   logic btnL;
   logic btnR;
   logic hold;
   wire [7:0] seg;
   wire [7:0] an;
   wire [PANEL_W-1:0] leds;

   integer seed;
   int unsigned cycles = 0;

   // Display reader state
   int lastDigit = -1;
   logic [7:0] seenMask = '0;
   logic [31:0] scanBuf = '0;
   logic [31:0] scanWord = '0;
   int scanCount = 0;

   // Reference model of the port registers and the queue
   logic [PANEL_W-1:0] expJ;
   logic [PANEL_W-1:0] expI;
   logic [31:0] expCount;
   int modelLevel;
   bit modelPending;

   panelTest dut0
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sw           (sw),
      .btnC         (btnC),
      .btnU         (btnU),
      .btnD         (btnD),
      .btnL         (btnL),
      .btnR         (btnR),
      .hold         (hold),
      .seg          (seg),
      .an           (an),
      .leds         (leds)
   );

   initial
   begin
      selected_clk = 1'b0;
      forever #2 selected_clk = ~selected_clk;
   end

   always @(posedge selected_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         abortRun();
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks and reference functions
   ////////////////////////////////////////////////////////////

   task automatic abortRun();
      $display("Verification failed");
      $fatal(1, "run stopped after an error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         abortRun();
      end
   endtask

   // Active-low gfedcba segment pattern of a hex digit
   function automatic logic [6:0] segRef(input logic [3:0] nib);
      logic [6:0] lit;
      case (nib)
         4'h0: lit = 7'h3f;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5b;
         4'h3: lit = 7'h4f;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6d;
         4'h6: lit = 7'h7d;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7f;
         4'h9: lit = 7'h6f;
         4'ha: lit = 7'h77;
         4'hb: lit = 7'h7c;
         4'hc: lit = 7'h39;
         4'hd: lit = 7'h5e;
         4'he: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   ////////////////////////////////////////////////////////////
   // Display reader that rebuilds one word per full scan
   ////////////////////////////////////////////////////////////

   always @(negedge selected_clk)
   begin : displayReader
      int digitIdx;
      int nib;
      if (res)
         lastDigit = -1;
      else if (an == 8'hff)
      begin
         // Blank display keeps every segment dark
         checkValue("seg", {24'd0, seg}, 32'hff);
         lastDigit = -1;
      end
      else
      begin
         digitIdx = -1;
         nib = -1;
         for (int i = 0; i < 8; i++)
            if (an == ~(8'd1 << i))
               digitIdx = i;
         for (int n = 0; n < 16; n++)
            if (seg == {1'b1, segRef(4'(n))})
               nib = n;
         if (digitIdx < 0)
         begin
            $display("Anode lines %h do not select exactly one digit", an);
            abortRun();
         end
         else if (nib < 0)
         begin
            $display("[FAIL] seg: got %h, not a hex digit pattern", seg);
            abortRun();
         end
         else
         begin
            if (digitIdx != lastDigit)
            begin
               if (lastDigit >= 0)
                  checkValue("digit order", 32'(digitIdx), 32'((lastDigit + 1) % 8));
               if (digitIdx == 0)
                  seenMask = '0;
               scanBuf[digitIdx*4 +: 4] = 4'(nib);
               seenMask[digitIdx] = 1'b1;
               if ((digitIdx == 7) && (seenMask == 8'hff))
               begin
                  scanWord = scanBuf;
                  scanCount = scanCount + 1;
               end
            end
            else
               checkValue("digit nibble", 32'(nib), {28'd0, scanBuf[digitIdx*4 +: 4]});
            lastDigit = digitIdx;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic nextDrive();
      @(posedge selected_clk);
      #1;
   endtask

   task automatic waitTicks(input int n);
      repeat (n * SAMPLE_DIV) nextDrive();
   endtask

   // Skips scans that may have latched the word before it settled
   task automatic readDisplay(input int scans, output logic [31:0] word);
      int target;
      target = scanCount + scans;
      wait (scanCount >= target);
      word = scanWord;
   endtask

   task automatic checkDisplay(input string name, input logic [31:0] exp);
      logic [31:0] word;
      readDisplay(2, word);
      checkValue(name, word, exp);
      checkValue("leds", {16'd0, leds}, {16'd0, exp[15:0]});
   endtask

   task automatic setSwitches(input logic [PANEL_W-1:0] v);
      nextDrive();
      sw = v;
      if (v != expJ)
         expCount = expCount + 32'd1;
      expJ = v;
      waitTicks(3);
   endtask

   task automatic setButtons(input logic [4:0] v);
      nextDrive();
      {btnL, btnR, btnU, btnD, btnC} = v;
   endtask

   // A press is consumed at once, queued, parked in the sampler or lost
   task automatic modelPress(input logic [4:0] v);
      if (!hold)
      begin
         expCount = expCount + 32'd1;
         expI = {11'd0, v};
      end
      else if (modelLevel < FIFO_DEPTH)
      begin
         modelLevel++;
         expI = {11'd0, v};
      end
      else if (!modelPending)
      begin
         modelPending = 1'b1;
         expI = {11'd0, v};
      end
   endtask

   task automatic modelDrain();
      expCount = expCount + 32'(modelLevel) + (modelPending ? 32'd1 : 32'd0);
      modelLevel = 0;
      modelPending = 1'b0;
   endtask

   initial
   begin : mainFlow
      logic [31:0] first;
      logic [31:0] second;
      logic [PANEL_W-1:0] swVal;
      seed = 32'hd22dbe24;
      res = 1'b1;
      sw = '0;
      btnC = 1'b0;
      btnU = 1'b0;
      btnD = 1'b0;
      btnL = 1'b0;
      btnR = 1'b0;
      hold = 1'b0;
      expJ = '0;
      expI = '0;
      expCount = '0;
      modelLevel = 0;
      modelPending = 1'b0;

      repeat (10) nextDrive();
      res = 1'b0;

      // Blank right after reset and zero on the first scan
      checkValue("an", {24'd0, an}, 32'hff);
      checkValue("seg", {24'd0, seg}, 32'hff);
      readDisplay(1, first);
      checkValue("display after reset", first, 32'd0);
      checkValue("leds", {16'd0, leds}, 32'd0);

      // Random switch words with the select field at zero
      for (int k = 0; k < 6; k++)
      begin
         swVal = 16'($random(seed)) & 16'hff0f;
         setSwitches(swVal);
         checkDisplay("switch display", {16'd0, expJ});
      end

      setSwitches({8'd0, SEL_BUTTONS, 4'd0});
      for (int b = 0; b < 5; b++)
      begin
         setButtons(5'd1 << b);
         modelPress(5'd1 << b);
         waitTicks(3);
         checkDisplay("button display", {16'd0, expI});
         setButtons(5'd0);
         waitTicks(3);
         checkDisplay("button display after release", {16'd0, expI});
      end

      setSwitches({8'd0, SEL_EVENTS, 4'd0});
      checkDisplay("event count", expCount);

      ////////////////////////////////////////////////////////////
      // Back-pressure from the hold switch
      ////////////////////////////////////////////////////////////

      setSwitches({8'd0, SEL_LEVEL, 4'd0});
      nextDrive();
      hold = 1'b1;
      for (int p = 0; p < 11; p++)
      begin
         setButtons(5'b00001);
         modelPress(5'b00001);
         waitTicks(2);
         setButtons(5'd0);
         waitTicks(2);
      end
      checkDisplay("FIFO level", 32'(modelLevel));
      nextDrive();
      hold = 1'b0;
      modelDrain();
      waitTicks(2);
      checkDisplay("FIFO level after drain", 32'd0);
      setSwitches({8'd0, SEL_EVENTS, 4'd0});
      checkDisplay("event count after drain", expCount);

      // Cycle counter advances by one scan period per scan
      setSwitches({8'd0, SEL_CYCLES, 4'd0});
      readDisplay(2, first);
      readDisplay(1, second);
      checkValue("cycle count rising", {31'd0, second > first}, 32'd1);
      checkValue("cycle count step", second - first, 32'(8 * SCAN_DIV));

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== panelTest.f ====
verilog/panelPkg.sv
verilog/panelSampler.sv
verilog/eventFifo.sv
verilog/panelPorts.sv
verilog/seg7Scanner.sv
verilog/panelTest.sv
tb/panelTestTb.sv

// ==== Makefile ====
# Verilator simulation of the front-panel test harness

VERILATOR ?= verilator
TOP       ?= panelTestTb
FILELIST  ?= panelTest.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# A failing run ends in $fatal, so the exit status reports the result
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
